/* include/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// data word width
`define WORD_W 32

// data RAM size in words, and word-index width
`define DRAM_WORDS 256
`define DRAM_AW 8

// external interrupt lines, mapped onto IP[7:2]
`define EXT_INT_W 6

// cause.ExcCode values
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10
`define EXC_OV   5'd12

`endif

/* rtl/mips_isa_pkg.sv */
`include "mips_defines.svh"

package mips_isa_pkg;

    // machine word
    typedef logic [`WORD_W-1:0] word_t;

    // gpr number
    typedef logic [4:0] creg_addr_t;

    // ops as seen by the memory stage
    // all arithmetic and logic collapses into ALU
    typedef enum logic [3:0] {
        ALU,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        SYSCALL,
        BREAK,
        ERET,
        NOP
    } decoded_op_t;

    // data access width
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } size_t;

endpackage

/* rtl/mips_pipe_pkg.sv */
package mips_pipe_pkg;

    // cp0 status, reg 12
    typedef struct packed {
        logic [15:0] rsvd_hi;
        // interrupt mask
        logic [7:0]  IM;
        logic [5:0]  rsvd_lo;
        // exception level
        logic        EXL;
        // global interrupt enable
        logic        IE;
    } cp0_status_t;

    // cp0 cause, reg 13
    typedef struct packed {
        logic        BD;
        logic [14:0] rsvd_hi;
        // pending interrupts, only [1:0] are software writable
        logic [7:0]  IP;
        logic        rsvd_7;
        logic [4:0]  ExcCode;
        logic [1:0]  rsvd_lo;
    } cp0_cause_t;

    // execute -> memory payload
    typedef struct packed {
        mips_isa_pkg::decoded_op_t op;
        // result or effective address
        mips_isa_pkg::word_t       aluout;
        // rt value for stores
        mips_isa_pkg::word_t       writedata;
        mips_isa_pkg::creg_addr_t  writereg;
        mips_isa_pkg::word_t       pcplus4;
        logic                      in_delay_slot;
        // flags raised upstream
        logic                      exc_fetch;
        logic                      exc_ri;
        logic                      exc_of;
        // cp0 snapshot travelling with the instr
        cp0_status_t               cp0_status;
        cp0_cause_t                cp0_cause;
    } exec_data_t;

    // memory -> writeback payload
    typedef struct packed {
        mips_isa_pkg::decoded_op_t op;
        mips_isa_pkg::word_t       result;
        mips_isa_pkg::creg_addr_t  writereg;
        logic                      regwrite;
    } mem_data_t;

endpackage

/* rtl/stage_reg.sv */
`timescale 1ns/100ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // valid bit, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload only loads with a live instr
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

    // downstream gating relies on a known valid once out of reset
    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

endmodule

/* rtl/store_align.sv */
`timescale 1ns/100ps

module store_align (
    input  logic [1:0]          addr_lo,
    input  mips_isa_pkg::size_t size,
    input  mips_isa_pkg::word_t wd_in,
    output logic [3:0]          byte_en,
    output mips_isa_pkg::word_t wd
);

    always_comb begin
        case (size)
            mips_isa_pkg::SZ_BYTE: begin
                // same byte on every lane
                wd      = {4{wd_in[7:0]}};
                byte_en = 4'b0001 << addr_lo;
            end
            mips_isa_pkg::SZ_HALF: begin
                // low half copied to both halves
                wd = {2{wd_in[15:0]}};
                // addr_lo[0] is an AdES case, not handled here
                if (addr_lo[1]) begin
                    byte_en = 4'b1100;
                end else begin
                    byte_en = 4'b0011;
                end
            end
            default: begin
                // full word
                wd      = wd_in;
                byte_en = 4'b1111;
            end
        endcase
    end

endmodule

/* rtl/load_extend.sv */
`timescale 1ns/100ps

module load_extend (
    input  logic [1:0]                addr_lo,
    input  mips_isa_pkg::decoded_op_t op,
    input  mips_isa_pkg::word_t       rd_in,
    output mips_isa_pkg::word_t       rd
);

    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    // addressed byte lane
    assign lane_b = rd_in[8*addr_lo +: 8];
    // upper or lower half
    assign lane_h = addr_lo[1] ? rd_in[31:16] : rd_in[15:0];

    always_comb begin
        case (op)
            mips_isa_pkg::LB:  rd = {{24{lane_b[7]}}, lane_b};
            mips_isa_pkg::LBU: rd = {24'd0, lane_b};
            mips_isa_pkg::LH:  rd = {{16{lane_h[15]}}, lane_h};
            mips_isa_pkg::LHU: rd = {16'd0, lane_h};
            // LW and anything else, word as read
            default:           rd = rd_in;
        endcase
    end

endmodule

/* rtl/data_ram.sv */
`timescale 1ns/100ps
`include "mips_defines.svh"

module data_ram (
    input  logic                clk,
    input  logic [`DRAM_AW-1:0] addr,
    input  logic [3:0]          byte_en,
    input  logic                wen,
    input  mips_isa_pkg::word_t wd,
    output mips_isa_pkg::word_t rd
);

    // word array
    mips_isa_pkg::word_t mem [`DRAM_WORDS];

    // lane-wise write
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[addr][8*i +: 8] <= wd[8*i +: 8];
                end
            end
        end
    end

    // async read, a load sees stores from earlier edges
    assign rd = mem[addr];

    // store path must always select at least one lane
    a_wen_lanes: assert property (@(posedge clk) wen |-> (byte_en != 4'b0000));

endmodule

/* rtl/mem_stage_ctrl.sv */
`timescale 1ns/100ps
`include "mips_defines.svh"

module mem_stage_ctrl (
    input  logic                       clk,
    input  logic                       valid,
    input  mips_isa_pkg::decoded_op_t  op,
    input  mips_isa_pkg::word_t        aluout,
    input  mips_isa_pkg::creg_addr_t   writereg,
    input  mips_isa_pkg::word_t        pcplus4,
    input  logic                       in_delay_slot,
    input  logic                       exc_fetch,
    input  logic                       exc_ri,
    input  logic                       exc_of,
    input  mips_pipe_pkg::cp0_status_t cp0_status,
    input  mips_pipe_pkg::cp0_cause_t  cp0_cause,
    input  logic [`EXT_INT_W-1:0]      ext_int,
    input  logic                       timer_interrupt,
    input  mips_isa_pkg::word_t        load_data,
    output mips_isa_pkg::size_t        size,
    output logic                       ram_wen,
    output logic                       exc_valid,
    output logic [4:0]                 exc_code,
    output mips_isa_pkg::word_t        exc_epc,
    output mips_isa_pkg::word_t        exc_bad_vaddr,
    output logic                       exc_bd,
    output logic                       eret,
    output logic                       wb_valid,
    output mips_pipe_pkg::mem_data_t   wb_data
);

    logic                is_load;
    logic                is_store;
    logic                misalign;
    logic                exc_load;
    logic                exc_save;
    logic [7:0]          int_pending;
    logic                take_int;
    logic                exc_hit;
    mips_isa_pkg::word_t pc;

    assign is_load  = op inside {mips_isa_pkg::LB, mips_isa_pkg::LBU, mips_isa_pkg::LH,
                                 mips_isa_pkg::LHU, mips_isa_pkg::LW};
    assign is_store = op inside {mips_isa_pkg::SB, mips_isa_pkg::SH, mips_isa_pkg::SW};

    // access width
    always_comb begin
        case (op)
            mips_isa_pkg::LB, mips_isa_pkg::LBU, mips_isa_pkg::SB: size = mips_isa_pkg::SZ_BYTE;
            mips_isa_pkg::LH, mips_isa_pkg::LHU, mips_isa_pkg::SH: size = mips_isa_pkg::SZ_HALF;
            default:                                               size = mips_isa_pkg::SZ_WORD;
        endcase
    end

    // half needs bit 0 clear, word needs both
    assign misalign = ((size == mips_isa_pkg::SZ_HALF) && aluout[0]) ||
                      ((size == mips_isa_pkg::SZ_WORD) && (aluout[1:0] != 2'b00));
    assign exc_load = is_load & misalign;
    assign exc_save = is_store & misalign;

    // hw lines on IP[7:2], timer on IP7, sw on IP[1:0]
    assign int_pending = ({ext_int, 2'b00} | {6'd0, cp0_cause.IP[1:0]} |
                          {timer_interrupt, 7'd0}) & cp0_status.IM;
    assign take_int = cp0_status.IE & ~cp0_status.EXL & (|int_pending);

    // fixed priority, interrupt first
    always_comb begin
        exc_hit = 1'b1;
        if (take_int) begin
            exc_code = `EXC_INT;
        end else if (exc_fetch) begin
            exc_code = `EXC_ADEL;
        end else if (exc_ri) begin
            exc_code = `EXC_RI;
        end else if (exc_of) begin
            exc_code = `EXC_OV;
        end else if (op == mips_isa_pkg::SYSCALL) begin
            exc_code = `EXC_SYS;
        end else if (op == mips_isa_pkg::BREAK) begin
            exc_code = `EXC_BP;
        end else if (exc_load) begin
            exc_code = `EXC_ADEL;
        end else if (exc_save) begin
            exc_code = `EXC_ADES;
        end else begin
            exc_hit  = 1'b0;
            exc_code = `EXC_INT;
        end
    end

    assign exc_valid = valid & exc_hit;

    // pc of this instr
    assign pc = pcplus4 - 32'd4;
    // delay slot restarts at the branch
    assign exc_epc       = in_delay_slot ? (pc - 32'd4) : pc;
    assign exc_bd        = exc_valid & in_delay_slot;
    assign exc_bad_vaddr = exc_fetch ? pc : aluout;

    // eret only completes if nothing was taken
    assign eret = valid & ~exc_hit & (op == mips_isa_pkg::ERET);

    // squash store and retire on exception
    assign ram_wen  = valid & is_store & ~exc_hit;
    assign wb_valid = valid & ~exc_hit;

    assign wb_data.op       = op;
    assign wb_data.result   = is_load ? load_data : aluout;
    assign wb_data.writereg = writereg;
    assign wb_data.regwrite = (op == mips_isa_pkg::ALU) | is_load;

    // an excepting instr never reaches the RAM, whatever its cause
    a_no_store_on_exc: assert property (@(posedge clk)
        ram_wen |-> !(take_int | exc_fetch | exc_ri | exc_of | exc_save));

endmodule

/* rtl/mem_subsys.sv */
`timescale 1ns/100ps
`include "mips_defines.svh"

module mem_subsys (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  mips_isa_pkg::decoded_op_t  in_op,
    input  mips_isa_pkg::word_t        in_aluout,
    input  mips_isa_pkg::word_t        in_writedata,
    input  mips_isa_pkg::creg_addr_t   in_writereg,
    input  mips_isa_pkg::word_t        in_pcplus4,
    input  logic                       in_in_delay_slot,
    input  logic                       in_exc_fetch,
    input  logic                       in_exc_ri,
    input  logic                       in_exc_of,
    input  mips_pipe_pkg::cp0_status_t in_cp0_status,
    input  mips_pipe_pkg::cp0_cause_t  in_cp0_cause,
    input  logic [`EXT_INT_W-1:0]      ext_int,
    input  logic                       timer_interrupt,
    output logic                       exc_valid,
    output logic [4:0]                 exc_code,
    output mips_isa_pkg::word_t        exc_epc,
    output mips_isa_pkg::word_t        exc_bad_vaddr,
    output logic                       exc_bd,
    output logic                       eret,
    output logic                       wb_valid,
    output mips_isa_pkg::decoded_op_t  wb_op,
    output mips_isa_pkg::word_t        wb_result,
    output mips_isa_pkg::creg_addr_t   wb_writereg,
    output logic                       wb_regwrite
);

    mips_pipe_pkg::exec_data_t ex_in;
    mips_pipe_pkg::exec_data_t m_data;
    logic                      m_valid;
    mips_pipe_pkg::mem_data_t  wb_next;
    logic                      wb_next_valid;
    mips_pipe_pkg::mem_data_t  w_data;
    mips_isa_pkg::size_t       acc_size;
    logic                      ram_wen;
    logic [3:0]                byte_en;
    mips_isa_pkg::word_t       store_wd;
    mips_isa_pkg::word_t       ram_rd;
    mips_isa_pkg::word_t       load_data;

    // bundle the execute side
    assign ex_in.op            = in_op;
    assign ex_in.aluout        = in_aluout;
    assign ex_in.writedata     = in_writedata;
    assign ex_in.writereg      = in_writereg;
    assign ex_in.pcplus4       = in_pcplus4;
    assign ex_in.in_delay_slot = in_in_delay_slot;
    assign ex_in.exc_fetch     = in_exc_fetch;
    assign ex_in.exc_ri        = in_exc_ri;
    assign ex_in.exc_of        = in_exc_of;
    assign ex_in.cp0_status    = in_cp0_status;
    assign ex_in.cp0_cause     = in_cp0_cause;

    // execute/memory register
    stage_reg #(.payload_t(mips_pipe_pkg::exec_data_t)) m_reg_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_data(ex_in),
        .out_valid(m_valid), .out_data(m_data)
    );

    mem_stage_ctrl ctrl_i (
        .clk(clk), .valid(m_valid), .op(m_data.op), .aluout(m_data.aluout),
        .writereg(m_data.writereg), .pcplus4(m_data.pcplus4),
        .in_delay_slot(m_data.in_delay_slot), .exc_fetch(m_data.exc_fetch),
        .exc_ri(m_data.exc_ri), .exc_of(m_data.exc_of),
        .cp0_status(m_data.cp0_status), .cp0_cause(m_data.cp0_cause),
        .ext_int(ext_int), .timer_interrupt(timer_interrupt), .load_data(load_data),
        .size(acc_size), .ram_wen(ram_wen), .exc_valid(exc_valid), .exc_code(exc_code),
        .exc_epc(exc_epc), .exc_bad_vaddr(exc_bad_vaddr), .exc_bd(exc_bd), .eret(eret),
        .wb_valid(wb_next_valid), .wb_data(wb_next)
    );

    store_align store_i (
        .addr_lo(m_data.aluout[1:0]), .size(acc_size), .wd_in(m_data.writedata),
        .byte_en(byte_en), .wd(store_wd)
    );

    // word index from the byte address
    data_ram ram_i (
        .clk(clk), .addr(m_data.aluout[`DRAM_AW+1:2]), .byte_en(byte_en),
        .wen(ram_wen), .wd(store_wd), .rd(ram_rd)
    );

    load_extend load_i (
        .addr_lo(m_data.aluout[1:0]), .op(m_data.op), .rd_in(ram_rd), .rd(load_data)
    );

    // memory/writeback register
    stage_reg #(.payload_t(mips_pipe_pkg::mem_data_t)) w_reg_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(wb_next_valid), .in_data(wb_next),
        .out_valid(wb_valid), .out_data(w_data)
    );

    assign wb_op       = w_data.op;
    assign wb_result   = w_data.result;
    assign wb_writereg = w_data.writereg;
    assign wb_regwrite = w_data.regwrite;

endmodule

/* testbench/tb_mem_subsys.sv */
`timescale 1ns/100ps
`include "mips_defines.svh"

module tb_mem_subsys;

    // one instr per two cycles, reset and some margin on top
    localparam int NUM_INSTR  = 2000;
    localparam int RESET_CYC  = 16;
    localparam int MAX_CYCLES = 2 * NUM_INSTR + RESET_CYC + 100;

    logic                       clk;
    logic                       rst_n;
    logic                       in_valid;
    mips_isa_pkg::decoded_op_t  in_op;
    mips_isa_pkg::word_t        in_aluout;
    mips_isa_pkg::word_t        in_writedata;
    mips_isa_pkg::creg_addr_t   in_writereg;
    mips_isa_pkg::word_t        in_pcplus4;
    logic                       in_in_delay_slot;
    logic                       in_exc_fetch;
    logic                       in_exc_ri;
    logic                       in_exc_of;
    mips_pipe_pkg::cp0_status_t in_cp0_status;
    mips_pipe_pkg::cp0_cause_t  in_cp0_cause;
    logic [`EXT_INT_W-1:0]      ext_int;
    logic                       timer_interrupt;
    logic                       exc_valid;
    logic [4:0]                 exc_code;
    mips_isa_pkg::word_t        exc_epc;
    mips_isa_pkg::word_t        exc_bad_vaddr;
    logic                       exc_bd;
    logic                       eret;
    logic                       wb_valid;
    mips_isa_pkg::decoded_op_t  wb_op;
    mips_isa_pkg::word_t        wb_result;
    mips_isa_pkg::creg_addr_t   wb_writereg;
    logic                       wb_regwrite;

    // reference copy of the data RAM
    logic [31:0] shadow [`DRAM_WORDS];

    int          check_count;
    int          error_count;
    int          cycle_count;
    int          inst_num;

    // prediction for the instr being issued
    logic        exp_exc;
    logic [4:0]  exp_code;
    logic [31:0] exp_epc;
    logic [31:0] exp_bad;
    logic        exp_chk_bad;
    logic        exp_eret;
    logic [31:0] exp_result;
    logic        exp_regwrite;
    logic        exp_store;
    logic        squashed;

    mem_subsys dut_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_op(in_op),
        .in_aluout(in_aluout), .in_writedata(in_writedata), .in_writereg(in_writereg),
        .in_pcplus4(in_pcplus4), .in_in_delay_slot(in_in_delay_slot),
        .in_exc_fetch(in_exc_fetch), .in_exc_ri(in_exc_ri), .in_exc_of(in_exc_of),
        .in_cp0_status(in_cp0_status), .in_cp0_cause(in_cp0_cause),
        .ext_int(ext_int), .timer_interrupt(timer_interrupt),
        .exc_valid(exc_valid), .exc_code(exc_code), .exc_epc(exc_epc),
        .exc_bad_vaddr(exc_bad_vaddr), .exc_bd(exc_bd), .eret(eret),
        .wb_valid(wb_valid), .wb_op(wb_op), .wb_result(wb_result),
        .wb_writereg(wb_writereg), .wb_regwrite(wb_regwrite)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // hard stop if the instr stream never finishes
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: writeback stream stalled");
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s (inst %0d): expected %h, actual %h",
                     name, inst_num, expected, actual);
        end
    endtask

    // lane pick plus sign or zero fill
    function automatic logic [31:0] extend_load(input mips_isa_pkg::decoded_op_t op,
                                                input logic [1:0] lo, input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * lo));
        h = 16'(word >> (16 * lo[1]));
        case (op)
            mips_isa_pkg::LB:  return {{24{b[7]}}, b};
            mips_isa_pkg::LBU: return {24'd0, b};
            mips_isa_pkg::LH:  return {{16{h[15]}}, h};
            mips_isa_pkg::LHU: return {16'd0, h};
            default:           return word;
        endcase
    endfunction

    // old word with the stored lanes replaced
    function automatic logic [31:0] merge_store(input mips_isa_pkg::decoded_op_t op,
                                                input logic [1:0] lo, input logic [31:0] old,
                                                input logic [31:0] data);
        logic [31:0] res;
        res = old;
        case (op)
            mips_isa_pkg::SB: res[8*lo +: 8] = data[7:0];
            mips_isa_pkg::SH: res[16*lo[1] +: 16] = data[15:0];
            mips_isa_pkg::SW: res = data;
            default: ;
        endcase
        return res;
    endfunction

    function automatic logic misaligned(input mips_isa_pkg::decoded_op_t op,
                                        input logic [1:0] lo);
        case (op)
            mips_isa_pkg::LH, mips_isa_pkg::LHU, mips_isa_pkg::SH: return lo[0];
            mips_isa_pkg::LW, mips_isa_pkg::SW:                    return lo != 2'b00;
            default:                                               return 1'b0;
        endcase
    endfunction

    task automatic predict();
        logic [7:0]  pending;
        logic        is_load;
        logic        is_store;
        logic        bad_addr;
        logic [31:0] pc;
        is_load  = in_op inside {mips_isa_pkg::LB, mips_isa_pkg::LBU, mips_isa_pkg::LH,
                                 mips_isa_pkg::LHU, mips_isa_pkg::LW};
        is_store = in_op inside {mips_isa_pkg::SB, mips_isa_pkg::SH, mips_isa_pkg::SW};
        bad_addr = misaligned(in_op, in_aluout[1:0]);
        // hw lines at 7..2, timer joins line 7, sw bits at 1..0
        pending      = 8'd0;
        pending[7:2] = ext_int;
        pending[1:0] = in_cp0_cause.IP[1:0];
        pending[7]   = pending[7] | timer_interrupt;
        pending      = pending & in_cp0_status.IM;
        exp_exc     = 1'b1;
        exp_chk_bad = 1'b0;
        if (in_cp0_status.IE && !in_cp0_status.EXL && pending != 8'd0) begin
            exp_code = `EXC_INT;
        end else if (in_exc_fetch) begin
            exp_code    = `EXC_ADEL;
            exp_chk_bad = 1'b1;
        end else if (in_exc_ri) begin
            exp_code = `EXC_RI;
        end else if (in_exc_of) begin
            exp_code = `EXC_OV;
        end else if (in_op == mips_isa_pkg::SYSCALL) begin
            exp_code = `EXC_SYS;
        end else if (in_op == mips_isa_pkg::BREAK) begin
            exp_code = `EXC_BP;
        end else if (is_load && bad_addr) begin
            exp_code    = `EXC_ADEL;
            exp_chk_bad = 1'b1;
        end else if (is_store && bad_addr) begin
            exp_code    = `EXC_ADES;
            exp_chk_bad = 1'b1;
        end else begin
            exp_exc  = 1'b0;
            exp_code = 5'd0;
        end
        pc       = in_pcplus4 - 32'd4;
        exp_epc  = in_in_delay_slot ? pc - 32'd4 : pc;
        exp_bad  = in_exc_fetch ? pc : in_aluout;
        exp_eret = (in_op == mips_isa_pkg::ERET) && !exp_exc;
        exp_store    = is_store && !exp_exc;
        squashed     = is_store && exp_exc;
        exp_regwrite = (in_op == mips_isa_pkg::ALU) || is_load;
        exp_result   = in_aluout;
        if (is_load) begin
            exp_result = extend_load(in_op, in_aluout[1:0],
                                     shadow[in_aluout[`DRAM_AW+1:2]]);
        end
    endtask

    // called on a falling edge, returns two falling edges later
    task automatic issue_instr();
        logic [`DRAM_AW-1:0] idx;
        in_valid = 1'b1;
        predict();
        @(negedge clk);
        // M cycle
        check_value("exc_valid", 32'(exp_exc), 32'(exc_valid));
        if (exp_exc) begin
            check_value("exc_code", 32'(exp_code), 32'(exc_code));
            check_value("exc_epc", exp_epc, exc_epc);
            check_value("exc_bd", 32'(in_in_delay_slot), 32'(exc_bd));
            if (exp_chk_bad) begin
                check_value("exc_bad_vaddr", exp_bad, exc_bad_vaddr);
            end
        end
        check_value("eret", 32'(exp_eret), 32'(eret));
        check_value("wb_valid during M", 32'd0, 32'(wb_valid));
        in_valid = 1'b0;
        // store lands on the coming edge
        if (exp_store) begin
            idx         = in_aluout[`DRAM_AW+1:2];
            shadow[idx] = merge_store(in_op, in_aluout[1:0], shadow[idx], in_writedata);
        end
        @(negedge clk);
        // writeback register now loaded
        check_value("wb_valid", 32'(!exp_exc), 32'(wb_valid));
        if (!exp_exc) begin
            check_value("wb_op", 32'(in_op), 32'(wb_op));
            check_value("wb_result", exp_result, wb_result);
            check_value("wb_writereg", 32'(in_writereg), 32'(wb_writereg));
            check_value("wb_regwrite", 32'(exp_regwrite), 32'(wb_regwrite));
        end
        check_value("exc_valid after M", 32'd0, 32'(exc_valid));
        inst_num++;
    endtask

    // no upstream flags, interrupts off
    task automatic quiet_context();
        in_exc_fetch     = 1'b0;
        in_exc_ri        = 1'b0;
        in_exc_of        = 1'b0;
        in_in_delay_slot = 1'b0;
        in_cp0_status    = '0;
        in_cp0_cause     = '0;
        ext_int          = '0;
        timer_interrupt  = 1'b0;
    endtask

    task automatic pick_random_instr();
        logic [3:0] sel;
        sel       = 4'($urandom % 13);
        in_op     = mips_isa_pkg::decoded_op_t'(sel);
        in_aluout = $urandom;
        // mostly aligned, one in eight left as drawn
        if ($urandom % 8 != 0) begin
            case (in_op)
                mips_isa_pkg::LH, mips_isa_pkg::LHU, mips_isa_pkg::SH: in_aluout[0] = 1'b0;
                mips_isa_pkg::LW, mips_isa_pkg::SW: in_aluout[1:0] = 2'b00;
                default: ;
            endcase
        end
        in_writedata     = $urandom;
        in_writereg      = 5'($urandom);
        in_pcplus4       = $urandom & 32'hffff_fffc;
        in_in_delay_slot = ($urandom % 4 == 0);
        in_exc_fetch     = ($urandom % 16 == 0);
        in_exc_ri        = ($urandom % 16 == 0);
        in_exc_of        = ($urandom % 16 == 0);
        // IP[7:2] and the rest of cause are noise that must be ignored
        in_cp0_status     = $urandom;
        in_cp0_status.IE  = ($urandom % 4 == 0);
        in_cp0_status.EXL = ($urandom % 4 == 0);
        in_cp0_cause      = $urandom;
        ext_int           = ($urandom % 4 == 0) ? `EXT_INT_W'($urandom) : '0;
        timer_interrupt   = ($urandom % 8 == 0);
    endtask

    initial begin
        void'($urandom(32'hac5590e3));
        check_count = 0;
        error_count = 0;
        cycle_count = 0;
        inst_num    = 0;
        rst_n       = 1'b0;
        // live instr held at the input through reset
        in_valid     = 1'b1;
        in_op        = mips_isa_pkg::SYSCALL;
        in_aluout    = 32'h0000_0003;
        in_writedata = 32'd0;
        in_writereg  = 5'd0;
        in_pcplus4   = 32'h0000_0100;
        quiet_context();

        for (int i = 0; i < RESET_CYC; i++) begin
            // syscall would raise exc_valid, eret would raise eret and wb_valid
            in_op = (i % 2 == 0) ? mips_isa_pkg::SYSCALL : mips_isa_pkg::ERET;
            @(negedge clk);
            check_value("reset exc_valid", 32'd0, 32'(exc_valid));
            check_value("reset eret", 32'd0, 32'(eret));
            check_value("reset wb_valid", 32'd0, 32'(wb_valid));
        end
        rst_n    = 1'b1;
        in_valid = 1'b0;
        quiet_context();
        @(negedge clk);
        check_value("post reset exc_valid", 32'd0, 32'(exc_valid));
        check_value("post reset eret", 32'd0, 32'(eret));
        check_value("post reset wb_valid", 32'd0, 32'(wb_valid));

        // fill every word, pattern mixes all index bits
        for (int i = 0; i < `DRAM_WORDS; i++) begin
            in_op        = mips_isa_pkg::SW;
            in_aluout    = {22'd0, `DRAM_AW'(i), 2'b00};
            in_writedata = 32'(i + 1) * 32'h9e37_79b9;
            in_writereg  = 5'($urandom);
            in_pcplus4   = 32'h0040_0000 + 32'(4 * i);
            issue_instr();
        end

        while (inst_num < NUM_INSTR) begin
            pick_random_instr();
            issue_instr();
            // reread a squashed store target
            if (squashed && inst_num < NUM_INSTR) begin
                quiet_context();
                in_op     = mips_isa_pkg::LW;
                in_aluout = in_aluout & 32'hffff_fffc;
                issue_instr();
            end
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/stage_reg.sv
rtl/store_align.sv
rtl/load_extend.sv
rtl/data_ram.sv
rtl/mem_stage_ctrl.sv
rtl/mem_subsys.sv
testbench/tb_mem_subsys.sv

/* Makefile */
SRCS := $(wildcard rtl/*.sv testbench/*.sv include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_mem_subsys: tb.f $(SRCS)
	verilator --binary --timing --assert -sv -f tb.f --top-module tb_mem_subsys \
		-o Vtb_mem_subsys

run: obj_dir/Vtb_mem_subsys
	./obj_dir/Vtb_mem_subsys > sim.log 2>&1; cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
